// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - files:
      - rtl/csr_pkg.sv
      - rtl/csr_op_unit.sv
      - rtl/csr_regfile.sv
      - rtl/csr_cycle_counter.sv
      - rtl/trap_ctrl.sv
      - rtl/csr_top.sv
  - target: simulation
    files:
      - dv/csr_tb.sv

// ==== dv/csr_tb.sv ====
`default_nettype none

module csr_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic                clk;
    logic                reset;
    csr_pkg::csr_req_t   csr_req;
    logic                csr_valid;
    csr_pkg::csr_rsp_t   csr_rsp;
    logic                rsp_valid;
    logic                trap_valid;
    csr_pkg::trap_req_t  trap;
    logic                mret_valid;
    logic                busy;
    logic                redirect_valid;
    csr_pkg::word_t      redirect_pc;

    logic [31:0] lfsr_state = 32'd27;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;

    csr_top #(
        .HART_ID (32'd5)
    ) DUT (
        .clk            (clk),
        .reset          (reset),
        .csr_req        (csr_req),
        .csr_valid      (csr_valid),
        .csr_rsp        (csr_rsp),
        .rsp_valid      (rsp_valid),
        .trap_valid     (trap_valid),
        .trap           (trap),
        .mret_valid     (mret_valid),
        .busy           (busy),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois form, one step per bit.
    function automatic logic lfsr_bit();
        lfsr_bit = lfsr_state[0];
        if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
        end else begin
            lfsr_state = lfsr_state >> 1;
        end
    endfunction

    function automatic csr_pkg::word_t rand_word();
        csr_pkg::word_t w;
        int             i;
        w = '0;
        for (i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr_bit()};
        end
        return w;
    endfunction

    function automatic csr_pkg::csr_rsp_t make_rsp(input csr_pkg::word_t d, input logic ill);
        csr_pkg::csr_rsp_t r;
        r.rdata   = d;
        r.illegal = ill;
        return r;
    endfunction

    function automatic csr_pkg::word_t field_mask(input csr_pkg::csr_addr_t addr);
        case (addr)
            csr_pkg::CSR_MSTATUS: return csr_pkg::MSTATUS_MASK;
            csr_pkg::CSR_MTVEC:   return csr_pkg::MTVEC_MASK;
            csr_pkg::CSR_MIP:     return csr_pkg::MIP_MASK;
            default:              return '1;
        endcase
    endfunction

    task automatic compare_rsp(input string what, input csr_pkg::csr_rsp_t got,
                               input csr_pkg::csr_rsp_t exp);
        checks++;
        if (got !== exp) begin
            $display("error at %0d ns: %s got rdata %h illegal %b, expected %h %b",
                     $time, what, got.rdata, got.illegal, exp.rdata, exp.illegal);
            errors++;
        end
    endtask

    task automatic compare_pc(input string what, input csr_pkg::word_t got,
                              input csr_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            $display("error at %0d ns: %s redirect_pc %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic compare_level(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // one request, then wait for its response.
    task automatic csr_access(input csr_pkg::csr_op_e op, input csr_pkg::csr_addr_t addr,
                              input csr_pkg::word_t src, output csr_pkg::csr_rsp_t rsp);
        csr_pkg::csr_req_t r;
        int                cycles;
        logic              done;
        r.op   = op;
        r.addr = addr;
        r.src  = src;
        @(posedge clk);
        csr_req   <= r;
        csr_valid <= 1'b1;
        @(posedge clk);
        csr_valid <= 1'b0;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < 20) begin
            @(negedge clk);
            if (rsp_valid) begin
                done = 1'b1;
            end
            cycles++;
        end
        if (done) begin
            rsp = csr_rsp;
        end else begin
            $display("no response to the request for address %h within 20 cycles", addr);
            errors++;
            rsp = '0;
        end
    endtask

    task automatic check_read(input csr_pkg::csr_addr_t addr, input csr_pkg::word_t exp);
        csr_pkg::csr_rsp_t rsp;
        csr_access(csr_pkg::CSR_RS, addr, '0, rsp);
        compare_rsp($sformatf("read of %h", addr), rsp, make_rsp(exp, 1'b0));
    endtask

    task automatic write_csr(input csr_pkg::csr_addr_t addr, input csr_pkg::word_t value);
        csr_pkg::csr_rsp_t rsp;
        csr_access(csr_pkg::CSR_RW, addr, value, rsp);
    endtask

    // strobe a trap or mret, optionally with a csr request while busy.
    task automatic strobe_trap(input logic mret, input csr_pkg::trap_req_t t, input logic probe,
                               output csr_pkg::word_t pc);
        csr_pkg::csr_req_t r;
        int                cycles;
        logic              done;
        logic              seen_rsp;
        r.op   = csr_pkg::CSR_RS;
        r.addr = csr_pkg::CSR_MSCRATCH;
        r.src  = '0;
        @(posedge clk);
        trap       <= t;
        trap_valid <= !mret;
        mret_valid <= mret;
        @(posedge clk);
        trap_valid <= 1'b0;
        mret_valid <= 1'b0;
        if (probe) begin
            csr_req   <= r;
            csr_valid <= 1'b1;
        end
        @(posedge clk);
        csr_valid <= 1'b0;
        cycles   = 0;
        done     = 1'b0;
        seen_rsp = 1'b0;
        while (!done && cycles < 20) begin
            @(negedge clk);
            compare_level("busy while a trap or mret is handled", busy, 1'b1);
            if (rsp_valid) begin
                seen_rsp = 1'b1;
            end
            if (redirect_valid) begin
                done = 1'b1;
            end
            cycles++;
        end
        pc = redirect_pc;
        if (done) begin
            @(negedge clk);
            compare_level("busy after the redirect", busy, 1'b0);
            compare_level("redirect_valid one cycle later", redirect_valid, 1'b0);
        end else begin
            $display("redirect_valid did not rise within 20 cycles");
            errors++;
        end
        if (probe && seen_rsp) begin
            $display("a csr request issued while busy got a response");
            errors++;
        end
    endtask

    task automatic test_done(input string name, input int errors_before);
        tests_run++;
        $display("%s finished with %0d errors", name, errors - errors_before);
    endtask

    task automatic reset_values();
        csr_pkg::csr_addr_t zero_addrs[9] = '{
            csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MTVEC, csr_pkg::CSR_MIP, csr_pkg::CSR_MIE,
            csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_MEPC, csr_pkg::CSR_MCAUSE, csr_pkg::CSR_MTVAL,
            csr_pkg::CSR_MCYCLEH};
        int                start;
        start = errors;
        @(negedge clk);
        compare_level("rsp_valid after reset", rsp_valid, 1'b0);
        compare_level("redirect_valid after reset", redirect_valid, 1'b0);
        compare_level("busy after reset", busy, 1'b0);
        // the last reset edge clears the count, a read sampled k edges later sees k - 1.
        check_read(csr_pkg::CSR_MCYCLE, 32'd1);
        check_read(csr_pkg::CSR_MCYCLE, 32'd3);
        foreach (zero_addrs[i]) begin
            check_read(zero_addrs[i], '0);
        end
        check_read(csr_pkg::CSR_MHARTID, 32'd5);
        test_done("reset_values", start);
    endtask

    task automatic read_modify_write();
        csr_pkg::csr_addr_t addrs[4] = '{csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_MSTATUS,
                                         csr_pkg::CSR_MTVEC, csr_pkg::CSR_MIP};
        csr_pkg::csr_op_e   ops[6] = '{csr_pkg::CSR_RW, csr_pkg::CSR_RS, csr_pkg::CSR_RC,
                                       csr_pkg::CSR_RW, csr_pkg::CSR_RC, csr_pkg::CSR_RS};
        csr_pkg::csr_rsp_t  rsp;
        csr_pkg::word_t     model;
        csr_pkg::word_t     src;
        int                 start;
        start = errors;
        foreach (addrs[a]) begin
            model = '0;
            foreach (ops[o]) begin
                src = rand_word();
                csr_access(ops[o], addrs[a], src, rsp);
                compare_rsp($sformatf("op %0d on %h", o, addrs[a]), rsp, make_rsp(model, 1'b0));
                case (ops[o])
                    csr_pkg::CSR_RW: model = src;
                    csr_pkg::CSR_RS: model = model | src;
                    default:         model = model & ~src;
                endcase
                model = model & field_mask(addrs[a]);
            end
            // set and clear with a zero source leave the value alone.
            csr_access(csr_pkg::CSR_RC, addrs[a], '0, rsp);
            compare_rsp("zero clear", rsp, make_rsp(model, 1'b0));
            check_read(addrs[a], model);
        end
        test_done("read_modify_write", start);
    endtask

    task automatic illegal_access();
        csr_pkg::csr_rsp_t rsp;
        csr_pkg::word_t    keep;
        int                start;
        start = errors;
        keep = rand_word();
        write_csr(csr_pkg::CSR_MSCRATCH, keep);
        csr_access(csr_pkg::CSR_RW, 12'h7C0, rand_word(), rsp);
        compare_rsp("unknown address", rsp, make_rsp('0, 1'b1));
        csr_access(csr_pkg::CSR_RW, csr_pkg::CSR_MHARTID, rand_word(), rsp);
        compare_rsp("mhartid write", rsp, make_rsp('0, 1'b1));
        csr_access(csr_pkg::CSR_RS, csr_pkg::CSR_MHARTID, 32'h1, rsp);
        compare_rsp("mhartid set", rsp, make_rsp('0, 1'b1));
        check_read(csr_pkg::CSR_MHARTID, 32'd5);
        check_read(csr_pkg::CSR_MSCRATCH, keep);
        test_done("illegal_access", start);
    endtask

    task automatic cycle_counter();
        csr_pkg::word_t v;
        csr_pkg::word_t h;
        int             k;
        int             start;
        start = errors;
        k = 5;
        // keep clear of a carry into the high word.
        v = rand_word() & 32'h7FFF_FFFF;
        write_csr(csr_pkg::CSR_MCYCLE, v);
        repeat (k - 2) @(posedge clk);
        check_read(csr_pkg::CSR_MCYCLE, v + k - 1);
        h = rand_word();
        write_csr(csr_pkg::CSR_MCYCLEH, h);
        check_read(csr_pkg::CSR_MCYCLEH, h);
        test_done("cycle_counter", start);
    endtask

    // status holds the expected mstatus and is moved past the trap.
    task automatic trap_case(input csr_pkg::word_t cause, input csr_pkg::word_t exp_pc,
                             input logic probe, inout csr_pkg::word_t status);
        csr_pkg::trap_req_t t;
        csr_pkg::word_t     pc;
        csr_pkg::word_t     exp_status;
        t.cause = cause;
        t.tval  = rand_word();
        t.pc    = rand_word() & ~32'h3;
        check_read(csr_pkg::CSR_MSTATUS, status);
        exp_status        = status;
        exp_status[7]     = status[3];
        exp_status[3]     = 1'b0;
        exp_status[12:11] = 2'b11;
        strobe_trap(1'b0, t, probe, pc);
        compare_pc($sformatf("trap cause %h", cause), pc, exp_pc);
        check_read(csr_pkg::CSR_MEPC, t.pc);
        check_read(csr_pkg::CSR_MCAUSE, cause);
        check_read(csr_pkg::CSR_MTVAL, t.tval);
        check_read(csr_pkg::CSR_MSTATUS, exp_status);
        status = exp_status;
    endtask

    task automatic trap_entry();
        csr_pkg::word_t base;
        csr_pkg::word_t status;
        int             start;
        start = errors;
        base   = rand_word() & ~32'h3;
        status = 32'h0000_0008;
        write_csr(csr_pkg::CSR_MSTATUS, status);
        write_csr(csr_pkg::CSR_MTVEC, base);
        trap_case(32'd2, base, 1'b1, status);
        write_csr(csr_pkg::CSR_MTVEC, base | 32'h1);
        trap_case(32'h8000_0007, base + 32'd28, 1'b0, status);
        // exceptions ignore vectored mode.
        trap_case(32'd5, base, 1'b1, status);
        test_done("trap_entry", start);
    endtask

    task automatic mret_case(input csr_pkg::word_t status);
        csr_pkg::word_t epc;
        csr_pkg::word_t pc;
        csr_pkg::word_t exp_status;
        epc = rand_word() & ~32'h3;
        write_csr(csr_pkg::CSR_MSTATUS, status);
        write_csr(csr_pkg::CSR_MEPC, epc);
        exp_status    = status;
        exp_status[3] = status[7];
        exp_status[7] = 1'b1;
        strobe_trap(1'b1, '0, 1'b1, pc);
        compare_pc("mret", pc, epc);
        check_read(csr_pkg::CSR_MSTATUS, exp_status);
    endtask

    task automatic mret_return();
        int start;
        start = errors;
        mret_case(32'h0000_1880);
        mret_case(32'h0000_1808);
        test_done("mret_return", start);
    endtask

    initial begin
        reset      = 1'b1;
        csr_req    = '0;
        csr_valid  = 1'b0;
        trap_valid = 1'b0;
        trap       = '0;
        mret_valid = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        reset_values();
        read_modify_write();
        illegal_access();
        cycle_counter();
        trap_entry();
        mret_return();
        repeat (2) @(posedge clk);
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/csr_cycle_counter.sv ====
`default_nettype none

module csr_cycle_counter (
    input  wire                   clk,
    input  wire                   reset,
    input  wire csr_pkg::csr_wr_t wr,
    output logic [63:0]           count
);

    logic wr_low;
    logic wr_high;

    assign wr_low  = wr.en && (wr.addr == csr_pkg::CSR_MCYCLE);
    assign wr_high = wr.en && (wr.addr == csr_pkg::CSR_MCYCLEH);

    // a software write replaces one word and skips the increment.
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (wr_low) begin
            count[31:0] <= wr.data;
        end else if (wr_high) begin
            count[63:32] <= wr.data;
        end else begin
            count <= count + 64'd1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/csr_op_unit.sv ====
`default_nettype none

module csr_op_unit (
    input  wire                   clk,
    input  wire                   reset,
    input  wire csr_pkg::csr_req_t req,
    input  wire                   req_valid,
    input  wire                   blocked,
    input  wire csr_pkg::word_t   old_value,
    output csr_pkg::csr_addr_t    raddr,
    output csr_pkg::csr_wr_t      wr,
    output csr_pkg::csr_rsp_t     rsp,
    output logic                  rsp_valid
);

    logic            take;
    logic            write_req;
    logic            legal;
    csr_pkg::word_t  new_value;

    // read happens at issue, so earlier writes are already visible.
    assign raddr = req.addr;

    assign take = req_valid && !blocked;

    // set and clear with a zero source only read.
    assign write_req = (req.op == csr_pkg::CSR_RW) || (req.src != '0);

    assign legal = csr_pkg::csr_exists(req.addr)
                && !(write_req && csr_pkg::csr_read_only(req.addr));

    always_comb begin
        case (req.op)
            csr_pkg::CSR_RW: new_value = req.src;
            csr_pkg::CSR_RS: new_value = old_value | req.src;
            csr_pkg::CSR_RC: new_value = old_value & ~req.src;
            default:         new_value = old_value;
        endcase
    end

    always_comb begin
        wr.en   = take && legal && write_req;
        wr.addr = req.addr;
        wr.data = new_value;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rsp.rdata   <= legal ? old_value : '0;
            rsp.illegal <= !legal;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [11:0] csr_addr_t;

    // encodings follow funct3 of the register forms.
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_e;

    typedef struct packed {
        csr_op_e   op;
        csr_addr_t addr;
        word_t     src;
    } csr_req_t;

    typedef struct packed {
        word_t rdata;
        logic  illegal;
    } csr_rsp_t;

    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        word_t     data;
    } csr_wr_t;

    typedef struct packed {
        word_t cause;
        word_t tval;
        word_t pc;
    } trap_req_t;

    typedef struct packed {
        logic  enter;
        logic  leave;
        word_t epc;
        word_t cause;
        word_t tval;
    } trap_upd_t;

    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_MIP      = 12'h344;
    localparam csr_addr_t CSR_MCYCLE   = 12'hB00;
    localparam csr_addr_t CSR_MCYCLEH  = 12'hB80;
    localparam csr_addr_t CSR_MHARTID  = 12'hF14;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;

    // mie, mpie and the two mpp bits.
    localparam word_t MSTATUS_MASK = 32'h0000_1888;
    // bit 1 of the mode field is reserved.
    localparam word_t MTVEC_MASK   = 32'hFFFF_FFFD;
    // msip, mtip and meip.
    localparam word_t MIP_MASK     = 32'h0000_0888;

    function automatic logic csr_exists(input csr_addr_t addr);
        case (addr)
            CSR_MSTATUS, CSR_MTVEC, CSR_MIP, CSR_MIE, CSR_MSCRATCH,
            CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MCYCLE, CSR_MCYCLEH,
            CSR_MHARTID: return 1'b1;
            default:     return 1'b0;
        endcase
    endfunction

    function automatic logic csr_read_only(input csr_addr_t addr);
        return addr == CSR_MHARTID;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/csr_regfile.sv ====
`default_nettype none

module csr_regfile #(
    parameter csr_pkg::word_t HART_ID = '0
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire csr_pkg::csr_addr_t raddr,
    input  wire csr_pkg::csr_wr_t   wr,
    input  wire csr_pkg::trap_upd_t upd,
    input  wire [63:0]              cycle_count,
    output csr_pkg::word_t          rdata,
    output csr_pkg::word_t          mtvec,
    output csr_pkg::word_t          mepc,
    output csr_pkg::word_t          mstatus
);

    csr_pkg::word_t mstatus_q;
    csr_pkg::word_t mtvec_q;
    csr_pkg::word_t mip_q;
    csr_pkg::word_t mie_q;
    csr_pkg::word_t mscratch_q;
    csr_pkg::word_t mepc_q;
    csr_pkg::word_t mcause_q;
    csr_pkg::word_t mtval_q;

    always_comb begin
        case (raddr)
            csr_pkg::CSR_MSTATUS:  rdata = mstatus_q;
            csr_pkg::CSR_MTVEC:    rdata = mtvec_q;
            csr_pkg::CSR_MIP:      rdata = mip_q;
            csr_pkg::CSR_MIE:      rdata = mie_q;
            csr_pkg::CSR_MSCRATCH: rdata = mscratch_q;
            csr_pkg::CSR_MEPC:     rdata = mepc_q;
            csr_pkg::CSR_MCAUSE:   rdata = mcause_q;
            csr_pkg::CSR_MTVAL:    rdata = mtval_q;
            csr_pkg::CSR_MCYCLE:   rdata = cycle_count[31:0];
            csr_pkg::CSR_MCYCLEH:  rdata = cycle_count[63:32];
            csr_pkg::CSR_MHARTID:  rdata = HART_ID;
            default:               rdata = '0;
        endcase
    end

    // trap updates come last so they win over a software write.
    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus_q  <= '0;
            mtvec_q    <= '0;
            mip_q      <= '0;
            mie_q      <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
        end else begin
            if (wr.en) begin
                case (wr.addr)
                    csr_pkg::CSR_MSTATUS:  mstatus_q  <= wr.data & csr_pkg::MSTATUS_MASK;
                    csr_pkg::CSR_MTVEC:    mtvec_q    <= wr.data & csr_pkg::MTVEC_MASK;
                    csr_pkg::CSR_MIP:      mip_q      <= wr.data & csr_pkg::MIP_MASK;
                    csr_pkg::CSR_MIE:      mie_q      <= wr.data;
                    csr_pkg::CSR_MSCRATCH: mscratch_q <= wr.data;
                    csr_pkg::CSR_MEPC:     mepc_q     <= wr.data;
                    csr_pkg::CSR_MCAUSE:   mcause_q   <= wr.data;
                    csr_pkg::CSR_MTVAL:    mtval_q    <= wr.data;
                    // counter words live in the cycle counter.
                    default: ;
                endcase
            end
            if (upd.enter) begin
                mepc_q   <= upd.epc;
                mcause_q <= upd.cause;
                mtval_q  <= upd.tval;
                mstatus_q[csr_pkg::MSTATUS_MPIE_BIT] <= mstatus_q[csr_pkg::MSTATUS_MIE_BIT];
                mstatus_q[csr_pkg::MSTATUS_MIE_BIT]  <= 1'b0;
                mstatus_q[csr_pkg::MSTATUS_MPP_LSB +: 2] <= 2'b11;
            end else if (upd.leave) begin
                mstatus_q[csr_pkg::MSTATUS_MIE_BIT]  <= mstatus_q[csr_pkg::MSTATUS_MPIE_BIT];
                mstatus_q[csr_pkg::MSTATUS_MPIE_BIT] <= 1'b1;
            end
        end
    end

    // trap controller needs the vector base and return address.
    assign mtvec   = mtvec_q;
    assign mepc    = mepc_q;
    assign mstatus = mstatus_q;

endmodule

`default_nettype wire

// ==== rtl/csr_top.sv ====
`default_nettype none

module csr_top #(
    parameter csr_pkg::word_t HART_ID = '0
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire csr_pkg::csr_req_t  csr_req,
    input  wire                     csr_valid,
    output csr_pkg::csr_rsp_t       csr_rsp,
    output logic                    rsp_valid,
    input  wire                     trap_valid,
    input  wire csr_pkg::trap_req_t trap,
    input  wire                     mret_valid,
    output logic                    busy,
    output logic                    redirect_valid,
    output csr_pkg::word_t          redirect_pc
);

    csr_pkg::csr_addr_t raddr;
    csr_pkg::word_t     old_value;
    csr_pkg::csr_wr_t   csr_wr;
    csr_pkg::trap_upd_t trap_upd;
    csr_pkg::word_t     mtvec;
    csr_pkg::word_t     mepc;
    logic [63:0]        cycle_count;
    logic               csr_blocked;

    // a trap or mret strobe drops a csr strobe on the same edge.
    assign csr_blocked = busy || trap_valid || mret_valid;

    csr_op_unit u_op_unit (
        .clk       (clk),
        .reset     (reset),
        .req       (csr_req),
        .req_valid (csr_valid),
        .blocked   (csr_blocked),
        .old_value (old_value),
        .raddr     (raddr),
        .wr        (csr_wr),
        .rsp       (csr_rsp),
        .rsp_valid (rsp_valid)
    );

    csr_regfile #(
        .HART_ID (HART_ID)
    ) u_regfile (
        .clk         (clk),
        .reset       (reset),
        .raddr       (raddr),
        .wr          (csr_wr),
        .upd         (trap_upd),
        .cycle_count (cycle_count),
        .rdata       (old_value),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .mstatus     ()
    );

    csr_cycle_counter u_cycle_counter (
        .clk   (clk),
        .reset (reset),
        .wr    (csr_wr),
        .count (cycle_count)
    );

    trap_ctrl u_trap_ctrl (
        .clk            (clk),
        .reset          (reset),
        .trap_valid     (trap_valid),
        .trap           (trap),
        .mret_valid     (mret_valid),
        .mtvec          (mtvec),
        .mepc           (mepc),
        .busy           (busy),
        .upd            (trap_upd),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

// ==== rtl/trap_ctrl.sv ====
`default_nettype none

module trap_ctrl (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     trap_valid,
    input  wire csr_pkg::trap_req_t trap,
    input  wire                     mret_valid,
    input  wire csr_pkg::word_t     mtvec,
    input  wire csr_pkg::word_t     mepc,
    output logic                    busy,
    output csr_pkg::trap_upd_t      upd,
    output logic                    redirect_valid,
    output csr_pkg::word_t          redirect_pc
);

    typedef enum logic [1:0] {
        IDLE,
        SAVE,
        REDIRECT
    } trap_state_e;

    trap_state_e        state;
    csr_pkg::trap_req_t trap_q;
    logic               is_mret;
    logic               accept;
    csr_pkg::word_t     base;
    csr_pkg::word_t     target;

    // strobes are ignored until the redirect pulse has gone.
    assign accept = (state == IDLE) && !redirect_valid && (trap_valid || mret_valid);
    assign busy   = (state != IDLE) || redirect_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:     if (accept) state <= SAVE;
                SAVE:     state <= REDIRECT;
                REDIRECT: state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    // a trap wins over an mret on the same edge.
    always_ff @(posedge clk) begin
        if (accept) begin
            trap_q  <= trap;
            is_mret <= !trap_valid;
        end
    end

    always_comb begin
        upd.enter = (state == SAVE) && !is_mret;
        upd.leave = (state == SAVE) && is_mret;
        upd.epc   = trap_q.pc;
        upd.cause = trap_q.cause;
        upd.tval  = trap_q.tval;
    end

    assign base = {mtvec[31:2], 2'b00};

    // vectored mode only applies to interrupts.
    always_comb begin
        if (is_mret) begin
            target = mepc;
        end else if (mtvec[0] && trap_q.cause[31]) begin
            target = base + {trap_q.cause[29:0], 2'b00};
        end else begin
            target = base;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= (state == REDIRECT);
        end
    end

    always_ff @(posedge clk) begin
        if (state == REDIRECT) begin
            redirect_pc <= target;
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/csr_pkg.sv
rtl/csr_op_unit.sv
rtl/csr_regfile.sv
rtl/csr_cycle_counter.sv
rtl/trap_ctrl.sv
rtl/csr_top.sv
dv/csr_tb.sv
